/* include/exu_settings.svh */
// width and sizing macros for the execution stage
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// integer data path
`define EXU_XLEN 32

// register file
`define EXU_RF_NUM 32
`define EXU_RFIDX_W 5

// outstanding load table depth and its log2 tag width
`define EXU_OITF_DEPTH 2
`define EXU_ITAG_W 1

// instruction word
`define EXU_INSTR_W 32

`endif

/* rtl/exu_pkg.sv */
// shared width types, alu op codes and inter-module structs
`default_nettype none
`include "exu_settings.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] xlen_t;
  typedef logic [`EXU_RFIDX_W-1:0] rfidx_t;
  typedef logic [`EXU_ITAG_W-1:0] itag_t;
  typedef logic [`EXU_INSTR_W-1:0] instr_t;

  // alu operation codes
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 3'd0;
  localparam alu_op_t ALU_SUB  = 3'd1;
  localparam alu_op_t ALU_AND  = 3'd2;
  localparam alu_op_t ALU_OR   = 3'd3;
  localparam alu_op_t ALU_XOR  = 3'd4;
  localparam alu_op_t ALU_SLT  = 3'd5;
  // forwards op2, used by lui
  localparam alu_op_t ALU_PASS = 3'd6;

  // decoded instruction
  typedef struct packed {
    alu_op_t op;
    rfidx_t  rs1idx;
    rfidx_t  rs2idx;
    rfidx_t  rdidx;
    logic    rs1en;
    logic    rs2en;
    logic    rdwen;
    logic    imm_sel;
    xlen_t   imm;
    logic    longpipe;
    logic    ilegl;
  } dec_info_t;

  // dispatch to alu
  typedef struct packed {
    alu_op_t op;
    xlen_t   op1;
    xlen_t   op2;
    rfidx_t  rdidx;
    logic    rdwen;
  } alu_req_t;

  // register file write
  typedef struct packed {
    rfidx_t rdidx;
    xlen_t  wdat;
  } wbck_t;

  // load unit command and response
  typedef struct packed {
    xlen_t addr;
    itag_t itag;
  } lsu_cmd_t;

  typedef struct packed {
    xlen_t rdata;
    itag_t itag;
  } lsu_rsp_t;

endpackage

`default_nettype wire

/* rtl/exu_decode.sv */
// instruction decoder for the add/sub/and/or/xor/slt, addi, lui and lw subset
`timescale 1ns/1ns
`default_nettype none
`include "exu_settings.svh"

module exu_decode import exu_pkg::*; (
  input  instr_t    i_instr,
  output dec_info_t o_dec
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rfidx_t     rs1idx;
  rfidx_t     rs2idx;
  rfidx_t     rdidx;
  logic       is_rtype;
  logic       is_addi;
  logic       is_lui;
  logic       is_lw;
  logic       legal;
  alu_op_t    rtype_op;
  xlen_t      imm_i;
  xlen_t      imm_u;

  assign opcode = i_instr[6:0];
  assign rdidx  = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign rs1idx = i_instr[19:15];
  assign rs2idx = i_instr[24:20];
  assign funct7 = i_instr[31:25];

  // register-register group
  always_comb begin
    is_rtype = (opcode == OPC_OP);
    case ({funct7, funct3})
      10'b0000000_000: rtype_op = ALU_ADD;
      10'b0100000_000: rtype_op = ALU_SUB;
      10'b0000000_111: rtype_op = ALU_AND;
      10'b0000000_110: rtype_op = ALU_OR;
      10'b0000000_100: rtype_op = ALU_XOR;
      10'b0000000_010: rtype_op = ALU_SLT;
      default: begin
        rtype_op = ALU_ADD;
        is_rtype = 1'b0;
      end
    endcase
  end

  assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == 3'b000);
  assign is_lui  = (opcode == OPC_LUI);
  assign is_lw   = (opcode == OPC_LOAD) && (funct3 == 3'b010);
  assign legal   = is_rtype | is_addi | is_lui | is_lw;

  // i-type sign extended, u-type upper 20 bits
  assign imm_i = {{(`EXU_XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_u = {i_instr[31:12], 12'b0};

  always_comb begin
    o_dec.op       = is_rtype ? rtype_op : (is_lui ? ALU_PASS : ALU_ADD);
    o_dec.rs1idx   = rs1idx;
    o_dec.rs2idx   = rs2idx;
    o_dec.rdidx    = rdidx;
    // x0 sources never need a hazard check
    o_dec.rs1en    = (is_rtype | is_addi | is_lw) && (rs1idx != '0);
    o_dec.rs2en    = is_rtype && (rs2idx != '0);
    o_dec.rdwen    = legal && (rdidx != '0);
    o_dec.imm_sel  = is_addi | is_lui | is_lw;
    o_dec.imm      = is_lui ? imm_u : imm_i;
    o_dec.longpipe = is_lw;
    o_dec.ilegl    = ~legal;
  end

endmodule

`default_nettype wire

/* rtl/exu_regfile.sv */
// integer register file, two read ports and one write port, x0 reads zero
`timescale 1ns/1ns
`default_nettype none
`include "exu_settings.svh"

module exu_regfile import exu_pkg::*; (
  input  logic   clk,
  input  logic   i_rst,
  input  rfidx_t i_rs1idx,
  input  rfidx_t i_rs2idx,
  output xlen_t  o_rs1,
  output xlen_t  o_rs2,
  input  logic   i_wen,
  input  wbck_t  i_wbck
);

  xlen_t regs [1:`EXU_RF_NUM-1];

  // a write in the same cycle is passed to the reader,
  // so an alu result being drained is seen by dispatch
  function automatic xlen_t rd_port(input rfidx_t idx);
    xlen_t val;
    if (idx == '0) begin
      val = '0;
    end else if (i_wen && (i_wbck.rdidx == idx)) begin
      val = i_wbck.wdat;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    o_rs1 = rd_port(i_rs1idx);
    o_rs2 = rd_port(i_rs2idx);
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 1; i < `EXU_RF_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_wbck.rdidx != '0)) begin
      regs[i_wbck.rdidx] <= i_wbck.wdat;
    end
  end

endmodule

`default_nettype wire

/* rtl/exu_disp.sv */
// dispatch with operand select, hazard stall and steering to alu or load command
`timescale 1ns/1ns
`default_nettype none
`include "exu_settings.svh"

module exu_disp import exu_pkg::*; (
  input  logic      i_valid,
  output logic      o_ready,
  input  dec_info_t i_dec,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  logic      i_match_rs1,
  input  logic      i_match_rs2,
  input  logic      i_match_rd,
  input  logic      i_oitf_full,
  input  itag_t     i_oitf_ptr,
  output logic      o_oitf_ena,
  output logic      o_alu_valid,
  input  logic      i_alu_ready,
  output alu_req_t  o_alu_req,
  output logic      o_lsu_cmd_valid,
  input  logic      i_lsu_cmd_ready,
  output lsu_cmd_t  o_lsu_cmd,
  output logic      o_ilegl
);

  logic  hazard;
  logic  alu_path;
  logic  lsu_path;
  logic  lsu_free;
  xlen_t op2;

  // raw or waw against a pending load
  assign hazard   = i_match_rs1 | i_match_rs2 | i_match_rd;
  assign alu_path = ~i_dec.ilegl & ~i_dec.longpipe;
  assign lsu_path = ~i_dec.ilegl & i_dec.longpipe;

  // a load also waits until the alu result register is empty or
  // draining, otherwise an older alu write could land after it
  assign lsu_free = ~hazard & ~i_oitf_full & i_alu_ready;

  assign o_alu_valid     = i_valid & alu_path & ~hazard;
  assign o_lsu_cmd_valid = i_valid & lsu_path & lsu_free;
  assign o_oitf_ena      = o_lsu_cmd_valid & i_lsu_cmd_ready;

  // illegal encodings are consumed at once
  always_comb begin
    if (i_dec.ilegl) begin
      o_ready = 1'b1;
    end else if (i_dec.longpipe) begin
      o_ready = lsu_free & i_lsu_cmd_ready;
    end else begin
      o_ready = ~hazard & i_alu_ready;
    end
  end

  assign o_ilegl = i_valid & i_dec.ilegl;

  assign op2 = i_dec.imm_sel ? i_dec.imm : i_rs2;

  assign o_alu_req = '{
    op:    i_dec.op,
    op1:   i_rs1,
    op2:   op2,
    rdidx: i_dec.rdidx,
    rdwen: i_dec.rdwen
  };

  // load address is rs1 + i-type offset
  assign o_lsu_cmd = '{addr: i_rs1 + i_dec.imm, itag: i_oitf_ptr};

endmodule

`default_nettype wire

/* rtl/exu_oitf.sv */
// outstanding load table with wrap-bit pointers and destination match
`timescale 1ns/1ns
`default_nettype none
`include "exu_settings.svh"

module exu_oitf import exu_pkg::*; (
  input  logic   clk,
  input  logic   i_rst,
  input  logic   i_disp_ena,
  input  rfidx_t i_disp_rdidx,
  output itag_t  o_disp_ptr,
  output logic   o_full,
  input  logic   i_ret_ena,
  output itag_t  o_ret_ptr,
  output rfidx_t o_ret_rdidx,
  input  rfidx_t i_rs1idx,
  input  rfidx_t i_rs2idx,
  input  rfidx_t i_rdidx,
  input  logic   i_rs1en,
  input  logic   i_rs2en,
  input  logic   i_rdwen,
  output logic   o_match_rs1,
  output logic   o_match_rs2,
  output logic   o_match_rd,
  output logic   o_empty
);

  localparam int    DEPTH = `EXU_OITF_DEPTH;
  localparam itag_t LAST  = itag_t'(DEPTH - 1);

  logic [DEPTH-1:0] vld;
  rfidx_t           rdidx [DEPTH];
  itag_t            dis_ptr;
  itag_t            ret_ptr;
  logic             dis_flg;
  logic             ret_flg;
  logic [DEPTH-1:0] hit_rs1;
  logic [DEPTH-1:0] hit_rs2;
  logic [DEPTH-1:0] hit_rd;

  // step a pointer, flipping the wrap bit at the last entry
  function automatic logic [`EXU_ITAG_W:0] bump(input logic flg, input itag_t ptr);
    return (ptr == LAST) ? {~flg, itag_t'(0)} : {flg, itag_t'(ptr + 1'b1)};
  endfunction

  always_ff @(posedge clk) begin
    if (i_rst) begin
      {dis_flg, dis_ptr} <= '0;
      {ret_flg, ret_ptr} <= '0;
    end else begin
      if (i_disp_ena) begin
        {dis_flg, dis_ptr} <= bump(dis_flg, dis_ptr);
      end
      if (i_ret_ena) begin
        {ret_flg, ret_ptr} <= bump(ret_flg, ret_ptr);
      end
    end
  end

  // dispatch and retire never hit the same slot in one cycle
  always_ff @(posedge clk) begin
    if (i_rst) begin
      vld <= '0;
    end else begin
      if (i_ret_ena) begin
        vld[ret_ptr] <= 1'b0;
      end
      if (i_disp_ena) begin
        vld[dis_ptr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_disp_ena) begin
      rdidx[dis_ptr] <= i_disp_rdidx;
    end
  end

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      hit_rs1[i] = vld[i] & i_rs1en & (rdidx[i] == i_rs1idx);
      hit_rs2[i] = vld[i] & i_rs2en & (rdidx[i] == i_rs2idx);
      hit_rd[i]  = vld[i] & i_rdwen & (rdidx[i] == i_rdidx);
    end
  end

  assign o_match_rs1 = |hit_rs1;
  assign o_match_rs2 = |hit_rs2;
  assign o_match_rd  = |hit_rd;

  // with equal pointers the wrap bits tell full from empty
  assign o_full  = (dis_ptr == ret_ptr) && (dis_flg != ret_flg);
  assign o_empty = (dis_ptr == ret_ptr) && (dis_flg == ret_flg);

  assign o_disp_ptr  = dis_ptr;
  assign o_ret_ptr   = ret_ptr;
  assign o_ret_rdidx = rdidx[ret_ptr];

endmodule

`default_nettype wire

/* rtl/exu_alu.sv */
// single-cycle alu with a one-entry result register
`timescale 1ns/1ns
`default_nettype none
`include "exu_settings.svh"

module exu_alu import exu_pkg::*; (
  input  logic     clk,
  input  logic     i_rst,
  input  logic     i_valid,
  output logic     o_ready,
  input  alu_req_t i_req,
  output logic     o_wbck_valid,
  input  logic     i_wbck_ready,
  output wbck_t    o_wbck
);

  xlen_t res;
  logic  slt;
  logic  res_vld;
  wbck_t res_r;

  //////////////////////////////////////////////////
  // datapath

  assign slt = $signed(i_req.op1) < $signed(i_req.op2);

  always_comb begin
    case (i_req.op)
      ALU_ADD:  res = i_req.op1 + i_req.op2;
      ALU_SUB:  res = i_req.op1 - i_req.op2;
      ALU_AND:  res = i_req.op1 & i_req.op2;
      ALU_OR:   res = i_req.op1 | i_req.op2;
      ALU_XOR:  res = i_req.op1 ^ i_req.op2;
      ALU_SLT:  res = {{(`EXU_XLEN-1){1'b0}}, slt};
      ALU_PASS: res = i_req.op2;
      default:  res = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // result register

  // empty, or being drained this cycle
  assign o_ready = ~res_vld | i_wbck_ready;

  // writes to x0 are computed and dropped
  always_ff @(posedge clk) begin
    if (i_rst) begin
      res_vld <= 1'b0;
    end else if (o_ready) begin
      res_vld <= i_valid & i_req.rdwen;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      res_r <= '{rdidx: i_req.rdidx, wdat: res};
    end
  end

  assign o_wbck_valid = res_vld;
  assign o_wbck       = res_r;

endmodule

`default_nettype wire

/* rtl/exu_wbck.sv */
// final write-back arbiter, load responses ahead of alu results
`timescale 1ns/1ns
`default_nettype none
`include "exu_settings.svh"

module exu_wbck import exu_pkg::*; (
  input  logic     i_alu_valid,
  output logic     o_alu_ready,
  input  wbck_t    i_alu,
  input  logic     i_rsp_valid,
  output logic     o_rsp_ready,
  input  lsu_rsp_t i_rsp,
  input  rfidx_t   i_ret_rdidx,
  output logic     o_ret_ena,
  output logic     o_wen,
  output wbck_t    o_wbck
);

  logic rsp_sel;

  // long-pipe always wins the port, so responses never wait
  assign o_rsp_ready = 1'b1;
  assign rsp_sel     = i_rsp_valid & o_rsp_ready;

  // responses come back in order, the oldest table entry owns the data
  assign o_ret_ena   = rsp_sel;
  assign o_alu_ready = ~rsp_sel;

  // a load to x0 still retires but writes nothing
  assign o_wen = rsp_sel ? (i_ret_rdidx != '0) : i_alu_valid;

  assign o_wbck = rsp_sel ? wbck_t'{rdidx: i_ret_rdidx, wdat: i_rsp.rdata} : i_alu;

endmodule

`default_nettype wire

/* rtl/exu.sv */
// execution stage top with decode, register file, dispatch, oitf, alu and write-back
`timescale 1ns/1ns
`default_nettype none
`include "exu_settings.svh"

module exu import exu_pkg::*; (
  input  logic     clk,
  input  logic     i_rst,
  input  logic     i_valid,
  output logic     o_ready,
  input  instr_t   i_instr,
  output logic     o_lsu_cmd_valid,
  input  logic     i_lsu_cmd_ready,
  output lsu_cmd_t o_lsu_cmd,
  input  logic     i_lsu_rsp_valid,
  output logic     o_lsu_rsp_ready,
  input  lsu_rsp_t i_lsu_rsp,
  output logic     o_wbck_ena,
  output wbck_t    o_wbck,
  output logic     o_ilegl,
  output logic     o_oitf_empty
);

  dec_info_t dec;
  xlen_t     rf_rs1;
  xlen_t     rf_rs2;
  logic      match_rs1;
  logic      match_rs2;
  logic      match_rd;
  logic      oitf_full;
  logic      oitf_ena;
  itag_t     oitf_ptr;
  logic      ret_ena;
  rfidx_t    ret_rdidx;
  logic      alu_valid;
  logic      alu_ready;
  alu_req_t  alu_req;
  logic      alu_wbck_valid;
  logic      alu_wbck_ready;
  wbck_t     alu_wbck;

  //////////////////////////////////////////////////
  // input side

  exu_decode u_decode (.i_instr(i_instr), .o_dec(dec));

  // write port mirrors the top-level write-back outputs
  exu_regfile u_regfile (
    .clk(clk), .i_rst(i_rst),
    .i_rs1idx(dec.rs1idx), .i_rs2idx(dec.rs2idx),
    .o_rs1(rf_rs1), .o_rs2(rf_rs2),
    .i_wen(o_wbck_ena), .i_wbck(o_wbck)
  );

  //////////////////////////////////////////////////
  // processing part

  exu_disp u_disp (
    .i_valid(i_valid), .o_ready(o_ready), .i_dec(dec),
    .i_rs1(rf_rs1), .i_rs2(rf_rs2),
    .i_match_rs1(match_rs1), .i_match_rs2(match_rs2), .i_match_rd(match_rd),
    .i_oitf_full(oitf_full), .i_oitf_ptr(oitf_ptr), .o_oitf_ena(oitf_ena),
    .o_alu_valid(alu_valid), .i_alu_ready(alu_ready), .o_alu_req(alu_req),
    .o_lsu_cmd_valid(o_lsu_cmd_valid), .i_lsu_cmd_ready(i_lsu_cmd_ready),
    .o_lsu_cmd(o_lsu_cmd), .o_ilegl(o_ilegl)
  );

  // return pointer is implied by in-order responses
  exu_oitf u_oitf (
    .clk(clk), .i_rst(i_rst),
    .i_disp_ena(oitf_ena), .i_disp_rdidx(dec.rdidx),
    .o_disp_ptr(oitf_ptr), .o_full(oitf_full),
    .i_ret_ena(ret_ena), .o_ret_ptr(), .o_ret_rdidx(ret_rdidx),
    .i_rs1idx(dec.rs1idx), .i_rs2idx(dec.rs2idx), .i_rdidx(dec.rdidx),
    .i_rs1en(dec.rs1en), .i_rs2en(dec.rs2en), .i_rdwen(dec.rdwen),
    .o_match_rs1(match_rs1), .o_match_rs2(match_rs2), .o_match_rd(match_rd),
    .o_empty(o_oitf_empty)
  );

  exu_alu u_alu (
    .clk(clk), .i_rst(i_rst),
    .i_valid(alu_valid), .o_ready(alu_ready), .i_req(alu_req),
    .o_wbck_valid(alu_wbck_valid), .i_wbck_ready(alu_wbck_ready), .o_wbck(alu_wbck)
  );

  //////////////////////////////////////////////////
  // output side

  exu_wbck u_wbck (
    .i_alu_valid(alu_wbck_valid), .o_alu_ready(alu_wbck_ready), .i_alu(alu_wbck),
    .i_rsp_valid(i_lsu_rsp_valid), .o_rsp_ready(o_lsu_rsp_ready), .i_rsp(i_lsu_rsp),
    .i_ret_rdidx(ret_rdidx), .o_ret_ena(ret_ena),
    .o_wen(o_wbck_ena), .o_wbck(o_wbck)
  );

endmodule

`default_nettype wire

/* tests/exu_tb.sv */
// execution stage testbench with pattern reader, load-unit model, write-back checks and watchdog
`timescale 1ns/1ns
`default_nettype none
`include "exu_settings.svh"

module exu_tb import exu_pkg::*; ();

  localparam int    MAX_PAT  = 64;
  localparam int    MARGIN   = 200;
  localparam xlen_t NO_WRITE = 32'h0000_00ff;
  localparam xlen_t ILLEGAL  = 32'h0000_00ee;

  typedef struct packed {
    logic [31:0] tnum;
    rfidx_t      rd;
    xlen_t       val;
  } expect_t;

  typedef struct packed {
    lsu_cmd_t    cmd;
    logic [31:0] due;
  } pend_t;

  logic        clk;
  logic        i_rst;
  logic        i_valid;
  logic        o_ready;
  instr_t      i_instr;
  logic        o_lsu_cmd_valid;
  logic        i_lsu_cmd_ready;
  lsu_cmd_t    o_lsu_cmd;
  logic        i_lsu_rsp_valid;
  logic        o_lsu_rsp_ready;
  lsu_rsp_t    i_lsu_rsp;
  logic        o_wbck_ena;
  wbck_t       o_wbck;
  logic        o_ilegl;
  logic        o_oitf_empty;

  xlen_t       pat_mem [0:2+3*MAX_PAT-1];
  xlen_t       key;
  int          n_pat;
  logic        loaded;
  expect_t     exp_q [$];
  pend_t       pend_q [$];
  logic [31:0] cyc;
  logic        held;
  lsu_cmd_t    held_cmd;
  itag_t       next_tag;
  int          n_chk;
  int          n_val_err;
  int          n_oth_err;
  int          n_ilegl;
  int          n_ilegl_exp;

  exu exu_i (.*);

  always #50 clk = ~clk;

  // oldest pending expectation for a register, -1 if none
  function automatic int oldest_for(input rfidx_t rd);
    int idx;
    idx = -1;
    for (int i = exp_q.size() - 1; i >= 0; i--) begin
      if (exp_q[i].rd == rd) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic check_wbck(input wbck_t wb);
    int      idx;
    expect_t e;
    idx = oldest_for(wb.rdidx);
    assert (idx >= 0) else begin
      $display("write-back to x%0d with %h that no instruction expects", wb.rdidx, wb.wdat);
      n_oth_err++;
    end
    if (idx >= 0) begin
      e = exp_q[idx];
      exp_q.delete(idx);
      n_chk++;
      assert (wb.wdat == e.val) else begin
        $display("Fail pattern %0d x%0d: expected %h, actual %h",
                 e.tnum, wb.rdidx, e.val, wb.wdat);
        n_val_err++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // load-unit model with random command ready and in-order responses after 0 to 5 cycles

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (i_lsu_rsp_valid && o_lsu_rsp_ready) begin
      void'(pend_q.pop_front());
    end
    if (o_lsu_cmd_valid && i_lsu_cmd_ready) begin
      pend_q.push_back('{cmd: o_lsu_cmd, due: cyc + ($urandom % 6)});
    end
    if (i_rst) begin
      i_lsu_cmd_ready <= 1'b0;
      i_lsu_rsp_valid <= 1'b0;
    end else begin
      i_lsu_cmd_ready <= ($urandom % 2) == 0;
      if (pend_q.size() > 0 && pend_q[0].due <= cyc) begin
        i_lsu_rsp_valid <= 1'b1;
        i_lsu_rsp       <= '{rdata: pend_q[0].cmd.addr ^ key, itag: pend_q[0].cmd.itag};
      end else begin
        i_lsu_rsp_valid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // monitors

  always @(posedge clk) begin
    if (!i_rst) begin
      if (o_wbck_ena) begin
        check_wbck(o_wbck);
      end
      if (o_ilegl) begin
        n_ilegl++;
      end
      // each load carries the next slot of the two-entry table
      if (o_lsu_cmd_valid && i_lsu_cmd_ready) begin
        assert (o_lsu_cmd.itag == next_tag) else begin
          $display("Fail load tag: expected %0d, actual %0d", next_tag, o_lsu_cmd.itag);
          n_val_err++;
        end
        next_tag = next_tag + 1'b1;
      end
      // a waiting command keeps valid and payload
      if (held) begin
        assert (o_lsu_cmd_valid && o_lsu_cmd == held_cmd) else begin
          $display("load command dropped or changed while waiting for ready");
          n_oth_err++;
        end
      end
      held     = o_lsu_cmd_valid && !i_lsu_cmd_ready;
      held_cmd = o_lsu_cmd;
    end
  end

  initial begin
    wait (loaded);
    repeat (n_pat * 20 + MARGIN) @(posedge clk);
    $display("watchdog expired before all patterns were written back");
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // pattern driver

  initial begin
    xlen_t instr;
    xlen_t dest;
    xlen_t val;
    void'($urandom(32'haf3b));
    clk             = 1'b0;
    i_rst           = 1'b1;
    i_valid         = 1'b0;
    i_instr         = '0;
    i_lsu_cmd_ready = 1'b0;
    i_lsu_rsp_valid = 1'b0;
    i_lsu_rsp       = '0;
    cyc             = '0;
    held            = 1'b0;
    next_tag        = '0;
    n_chk           = 0;
    n_val_err       = 0;
    n_oth_err       = 0;
    n_ilegl         = 0;
    n_ilegl_exp     = 0;
    $readmemh("tests/exu_patterns.txt", pat_mem);
    key    = pat_mem[0];
    n_pat  = pat_mem[1];
    loaded = 1'b1;
    assert (n_pat > 0 && n_pat <= MAX_PAT) else begin
      $display("pattern file missing or its count is out of range");
      n_oth_err++;
    end
    repeat (10) @(posedge clk);
    i_rst <= 1'b0;
    for (int p = 0; p < n_pat; p++) begin
      instr = pat_mem[2 + 3*p];
      dest  = pat_mem[3 + 3*p];
      val   = pat_mem[4 + 3*p];
      if (dest == ILLEGAL) begin
        n_ilegl_exp++;
      end else if (dest != NO_WRITE) begin
        exp_q.push_back('{tnum: p + 1, rd: rfidx_t'(dest), val: val});
      end
      i_valid <= 1'b1;
      i_instr <= instr;
      do begin
        @(posedge clk);
      end while (!o_ready);
    end
    i_valid <= 1'b0;
    while (exp_q.size() > 0) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    assert (o_oitf_empty) else begin
      $display("loads still outstanding after the last pattern");
      n_oth_err++;
    end
    assert (n_ilegl == n_ilegl_exp) else begin
      $display("%0d illegal pulses seen for %0d illegal instructions", n_ilegl, n_ilegl_exp);
      n_oth_err++;
    end
    $display("checks %0d, value errors %0d, other errors %0d", n_chk, n_val_err, n_oth_err);
    if (n_val_err == 0 && n_oth_err == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* exu.f */
+incdir+include
rtl/exu_pkg.sv
rtl/exu_decode.sv
rtl/exu_regfile.sv
rtl/exu_disp.sv
rtl/exu_oitf.sv
rtl/exu_alu.sv
rtl/exu_wbck.sv
rtl/exu.sv
tests/exu_tb.sv

/* tests/exu_patterns.txt */
// header: load key (load data = address ^ key), then pattern count
// patterns: instruction, destination (ff = no write, ee = illegal), expected value
A5000000
0000001F
// alu operations
06400093 00000001 00000064
FFD00113 00000002 FFFFFFFD
002081B3 00000003 00000061
40208233 00000004 00000067
0030F2B3 00000005 00000060
0030E333 00000006 00000065
0020C3B3 00000007 FFFFFF99
00112433 00000008 00000001
0020A4B3 00000009 00000000
12345537 0000000A 12345000
// writes to x0
00208033 000000FF 00000000
00000013 000000FF 00000000
// loads, raw use and a third load behind two pending
0100A583 0000000B A5000074
00158633 0000000C A50000D8
0001A683 0000000D A5000061
FFC22703 0000000E A5000063
0082A783 0000000F A5000068
// waw on x13
00500693 0000000D 00000005
// mul and slti are outside the subset
02208833 000000EE 00000000
0010A893 000000EE 00000000
// load to x0
0040A003 000000FF 00000000
00A64833 00000010 B73450D8
FFFFF137 00000002 FFFFF000
402008B3 00000011 00001000
0008A903 00000012 A5001000
000929B3 00000013 00000001
01290933 00000012 4A002000
000A2A03 00000014 A5000000
00402A83 00000015 A5000004
015A6B33 00000016 A5000004
FFFFFFFF 000000EE 00000000
